/* hdl/soc_map_pkg.sv */
// ============================
// Address map of the memory-side fabric. SRAM starts at 0 and is
// word addressed; MMIO occupies one 256-byte page at 0x0300_0000
// ============================
`default_nettype none

package soc_map_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;

  // external SRAM, 128 KiB
  localparam int MEM_WORDS  = 32768;
  localparam int RAM_ADDR_W = 15;
  localparam logic [ADDR_W-1:0] RAM_LIMIT = ADDR_W'(4 * MEM_WORDS);

  // upper address bits of the MMIO page
  localparam logic [ADDR_W-9:0] MMIO_BASE_HI = 24'h030000;

  // byte offsets inside the MMIO page
  typedef enum logic [7:0] {
    GPIO_OUT  = 8'h00,
    GPIO_OEB  = 8'h04,
    GPIO_PU   = 8'h08,
    GPIO_PD   = 8'h0c,
    PLL_DEST  = 8'h38,
    TRAP_DEST = 8'h3c,
    IRQ7_SRC  = 8'h40,
    IRQ8_SRC  = 8'h44
  } reg_off_e;

endpackage

`default_nettype wire

/* hdl/gpio_pkg.sv */
// ============================
// GPIO pad and interrupt definitions. Pins 8..10 and 11..13 are
// the only pins that the routing registers can take over
// ============================
`default_nettype none

package gpio_pkg;

  localparam int GPIO_W      = 16;
  localparam int IRQ_W       = 32;

  // interrupt vector bit positions
  localparam int IRQ_PIN_BIT = 5;
  localparam int IRQ_SPI_BIT = 6;
  localparam int IRQ_7_BIT   = 7;
  localparam int IRQ_8_BIT   = 8;

  // routed pin ranges
  localparam int PLL_PIN_LO    = 8;
  localparam int PLL_PIN_HI    = 10;
  localparam int TRAP_PIN_LO   = 11;
  localparam int TRAP_PIN_HI   = 13;
  // first gpio_in pin of each irq selector
  localparam int IRQ7_PIN_BASE = 0;
  localparam int IRQ8_PIN_BASE = 3;

  typedef enum logic [1:0] {PLL_NONE, PLL_PIN8, PLL_PIN9} pll_dest_e;

  typedef enum logic [1:0] {TRAP_NONE, TRAP_PIN11, TRAP_PIN12, TRAP_PIN13} trap_dest_e;

  // value n picks the n-th candidate pin, 0 turns the source off
  typedef enum logic [1:0] {SRC_OFF, SRC_IN0, SRC_IN1, SRC_IN2} irq_src_e;

endpackage

`default_nettype wire

/* hdl/mem_bus_fabric.sv */
// ============================
// Valid/ready decoder for a single non-pipelining master.
// Every target answers one cycle after the first cycle of valid;
// unmapped addresses complete with zero read data
// ============================
`timescale 1ns/100ps
`default_nettype none

module mem_bus_fabric (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               mem_valid_i,
  input  logic [soc_map_pkg::ADDR_W-1:0]     mem_addr_i,
  input  logic [soc_map_pkg::DATA_W-1:0]     mem_wdata_i,
  input  logic [soc_map_pkg::STRB_W-1:0]     mem_wstrb_i,
  output logic                               mem_ready_o,
  output logic [soc_map_pkg::DATA_W-1:0]     mem_rdata_o,
  output logic [soc_map_pkg::RAM_ADDR_W-1:0] ram_addr_o,
  output logic [soc_map_pkg::DATA_W-1:0]     ram_wdata_o,
  output logic [soc_map_pkg::STRB_W-1:0]     ram_wstrb_o,
  input  logic [soc_map_pkg::DATA_W-1:0]     ram_rdata_i,
  output logic [7:0]                         reg_off_o,
  output logic [soc_map_pkg::DATA_W-1:0]     reg_wdata_o,
  output logic [soc_map_pkg::STRB_W-1:0]     reg_we_o,
  input  logic [soc_map_pkg::DATA_W-1:0]     reg_rdata_i
);
  import soc_map_pkg::*;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_RAM,
    TGT_MMIO
  } tgt_e;

  logic              req_first;
  logic              sel_ram;
  logic              sel_mmio;
  tgt_e              tgt_d;
  tgt_e              tgt_q;
  logic [DATA_W-1:0] mmio_rdata_q;

  // valid stays high during the ready cycle, so that cycle is not new
  assign req_first = mem_valid_i && !mem_ready_o;
  assign sel_ram   = mem_addr_i < RAM_LIMIT;
  assign sel_mmio  = mem_addr_i[ADDR_W-1:8] == MMIO_BASE_HI;

  always_comb begin
    if (sel_ram) begin
      tgt_d = TGT_RAM;
    end else if (sel_mmio) begin
      tgt_d = TGT_MMIO;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  // sram port, data comes back one cycle after the address
  assign ram_addr_o  = mem_addr_i[RAM_ADDR_W+1:2];
  assign ram_wdata_o = mem_wdata_i;
  assign ram_wstrb_o = (req_first && tgt_d == TGT_RAM) ? mem_wstrb_i : '0;

  // register file port
  assign reg_off_o   = mem_addr_i[7:0];
  assign reg_wdata_o = mem_wdata_i;
  assign reg_we_o    = (req_first && tgt_d == TGT_MMIO) ? mem_wstrb_i : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_ready_o <= 1'b0;
      tgt_q       <= TGT_NONE;
    end else begin
      mem_ready_o <= req_first;
      if (req_first) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // mmio read value is taken before the write lands
  always_ff @(posedge clk_i) begin
    if (req_first) begin
      mmio_rdata_q <= reg_rdata_i;
    end
  end

  always_comb begin
    case (tgt_q)
      TGT_RAM:  mem_rdata_o = ram_rdata_i;
      TGT_MMIO: mem_rdata_o = mmio_rdata_q;
      default:  mem_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/gpio_regs.sv */
// ============================
// GPIO, routing and irq-select registers of the MMIO page.
// Unknown offsets read zero and drop writes
// ============================
`timescale 1ns/100ps
`default_nettype none

module gpio_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [7:0]                     reg_off_i,
  input  logic [soc_map_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic [soc_map_pkg::STRB_W-1:0] reg_we_i,
  input  logic [gpio_pkg::GPIO_W-1:0]    pin_out_i,
  input  logic [gpio_pkg::GPIO_W-1:0]    gpio_in_i,
  output logic [soc_map_pkg::DATA_W-1:0] reg_rdata_o,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_o,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_oeb_o,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_pu_o,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_pd_o,
  output gpio_pkg::pll_dest_e            pll_dest_o,
  output gpio_pkg::trap_dest_e           trap_dest_o,
  output gpio_pkg::irq_src_e             irq7_src_o,
  output gpio_pkg::irq_src_e             irq8_src_o
);
  import soc_map_pkg::*;
  import gpio_pkg::*;

  // byte-strobed update of a 16-bit register
  function automatic logic [GPIO_W-1:0] merge_bytes(
    input logic [GPIO_W-1:0] old_val,
    input logic [DATA_W-1:0] wdata,
    input logic [STRB_W-1:0] we
  );
    logic [GPIO_W-1:0] res;
    res = old_val;
    for (int b = 0; b < GPIO_W / 8; b++) begin
      if (we[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o      <= '0;
      gpio_oeb_o  <= '1;
      gpio_pu_o   <= '0;
      gpio_pd_o   <= '0;
      pll_dest_o  <= PLL_NONE;
      trap_dest_o <= TRAP_NONE;
      irq7_src_o  <= SRC_OFF;
      irq8_src_o  <= SRC_OFF;
    end else if (|reg_we_i) begin
      case (reg_off_i)
        GPIO_OUT:  gpio_o     <= merge_bytes(gpio_o, reg_wdata_i, reg_we_i);
        GPIO_OEB:  gpio_oeb_o <= merge_bytes(gpio_oeb_o, reg_wdata_i, reg_we_i);
        GPIO_PU:   gpio_pu_o  <= merge_bytes(gpio_pu_o, reg_wdata_i, reg_we_i);
        GPIO_PD:   gpio_pd_o  <= merge_bytes(gpio_pd_o, reg_wdata_i, reg_we_i);
        // 2-bit selectors live in byte 0
        PLL_DEST:  if (reg_we_i[0]) pll_dest_o <= pll_dest_e'(reg_wdata_i[1:0]);
        TRAP_DEST: if (reg_we_i[0]) trap_dest_o <= trap_dest_e'(reg_wdata_i[1:0]);
        IRQ7_SRC:  if (reg_we_i[0]) irq7_src_o <= irq_src_e'(reg_wdata_i[1:0]);
        IRQ8_SRC:  if (reg_we_i[0]) irq8_src_o <= irq_src_e'(reg_wdata_i[1:0]);
        default:   ;
      endcase
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_off_i)
      // pads as driven, after routing, in the upper half
      GPIO_OUT:  reg_rdata_o[2*GPIO_W-1:0] = {pin_out_i, gpio_in_i};
      GPIO_OEB:  reg_rdata_o[GPIO_W-1:0] = gpio_oeb_o;
      GPIO_PU:   reg_rdata_o[GPIO_W-1:0] = gpio_pu_o;
      GPIO_PD:   reg_rdata_o[GPIO_W-1:0] = gpio_pd_o;
      PLL_DEST:  reg_rdata_o[1:0] = pll_dest_o;
      TRAP_DEST: reg_rdata_o[1:0] = trap_dest_o;
      IRQ7_SRC:  reg_rdata_o[1:0] = irq7_src_o;
      IRQ8_SRC:  reg_rdata_o[1:0] = irq8_src_o;
      default:   ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/gpio_pin_mux.sv */
// ============================
// Pad routing and irq vector, purely combinational.
// clk_i is passed to a pad as data when the PLL route is on;
// all pads are tristated while rst_n_i is low
// ============================
`timescale 1ns/100ps
`default_nettype none

module gpio_pin_mux (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         trap_i,
  input  logic [gpio_pkg::GPIO_W-1:0]  gpio_in_i,
  input  logic                         irq_pin_i,
  input  logic                         irq_spi_i,
  input  logic [gpio_pkg::GPIO_W-1:0]  gpio_i,
  input  logic [gpio_pkg::GPIO_W-1:0]  gpio_oeb_i,
  input  logic [gpio_pkg::GPIO_W-1:0]  gpio_pu_i,
  input  logic [gpio_pkg::GPIO_W-1:0]  gpio_pd_i,
  input  gpio_pkg::pll_dest_e          pll_dest_i,
  input  gpio_pkg::trap_dest_e         trap_dest_i,
  input  gpio_pkg::irq_src_e           irq7_src_i,
  input  gpio_pkg::irq_src_e           irq8_src_i,
  output logic [gpio_pkg::GPIO_W-1:0]  gpio_out_o,
  output logic [gpio_pkg::GPIO_W-1:0]  gpio_outenb_o,
  output logic [gpio_pkg::GPIO_W-1:0]  gpio_pullupb_o,
  output logic [gpio_pkg::GPIO_W-1:0]  gpio_pulldownb_o,
  output logic [gpio_pkg::IRQ_W-1:0]   irq_o
);
  import gpio_pkg::*;

  function automatic logic pick_src(input irq_src_e src, input logic [2:0] pins);
    case (src)
      SRC_IN0: return pins[0];
      SRC_IN1: return pins[1];
      SRC_IN2: return pins[2];
      default: return 1'b0;
    endcase
  endfunction

  always_comb begin
    gpio_out_o       = gpio_i;
    gpio_outenb_o    = gpio_oeb_i;
    gpio_pullupb_o   = gpio_pu_i;
    gpio_pulldownb_o = gpio_pd_i;

    // whole pll group is driven with pulls off once routed
    if (pll_dest_i != PLL_NONE) begin
      gpio_outenb_o[PLL_PIN_HI:PLL_PIN_LO]    = '0;
      gpio_pullupb_o[PLL_PIN_HI:PLL_PIN_LO]   = '1;
      gpio_pulldownb_o[PLL_PIN_HI:PLL_PIN_LO] = '1;
    end
    case (pll_dest_i)
      PLL_PIN8: gpio_out_o[PLL_PIN_LO] = clk_i;
      PLL_PIN9: gpio_out_o[PLL_PIN_LO+1] = clk_i;
      default:  ;
    endcase

    if (trap_dest_i != TRAP_NONE) begin
      gpio_outenb_o[TRAP_PIN_HI:TRAP_PIN_LO]    = '0;
      gpio_pullupb_o[TRAP_PIN_HI:TRAP_PIN_LO]   = '1;
      gpio_pulldownb_o[TRAP_PIN_HI:TRAP_PIN_LO] = '1;
    end
    case (trap_dest_i)
      TRAP_PIN11: gpio_out_o[TRAP_PIN_LO] = trap_i;
      TRAP_PIN12: gpio_out_o[TRAP_PIN_LO+1] = trap_i;
      TRAP_PIN13: gpio_out_o[TRAP_PIN_LO+2] = trap_i;
      default:    ;
    endcase

    if (!rst_n_i) begin
      gpio_outenb_o = '1;
    end
  end

  always_comb begin
    irq_o              = '0;
    irq_o[IRQ_PIN_BIT] = irq_pin_i;
    irq_o[IRQ_SPI_BIT] = irq_spi_i;
    irq_o[IRQ_7_BIT]   = pick_src(irq7_src_i, gpio_in_i[IRQ7_PIN_BASE +: 3]);
    irq_o[IRQ_8_BIT]   = pick_src(irq8_src_i, gpio_in_i[IRQ8_PIN_BASE +: 3]);
  end

endmodule

`default_nettype wire

/* hdl/soc_periph_top.sv */
// ============================
// Memory-side fabric with the CPU bus as the top-level port.
// The master must hold a request until ready and never pipeline
// ============================
`timescale 1ns/100ps
`default_nettype none

module soc_periph_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               mem_valid_i,
  input  logic [soc_map_pkg::ADDR_W-1:0]     mem_addr_i,
  input  logic [soc_map_pkg::DATA_W-1:0]     mem_wdata_i,
  input  logic [soc_map_pkg::STRB_W-1:0]     mem_wstrb_i,
  output logic                               mem_ready_o,
  output logic [soc_map_pkg::DATA_W-1:0]     mem_rdata_o,
  output logic [soc_map_pkg::RAM_ADDR_W-1:0] ram_addr_o,
  output logic [soc_map_pkg::DATA_W-1:0]     ram_wdata_o,
  output logic [soc_map_pkg::STRB_W-1:0]     ram_wstrb_o,
  input  logic [soc_map_pkg::DATA_W-1:0]     ram_rdata_i,
  input  logic                               trap_i,
  input  logic [gpio_pkg::GPIO_W-1:0]        gpio_in_i,
  input  logic                               irq_pin_i,
  input  logic                               irq_spi_i,
  output logic [gpio_pkg::GPIO_W-1:0]        gpio_out_o,
  output logic [gpio_pkg::GPIO_W-1:0]        gpio_outenb_o,
  output logic [gpio_pkg::GPIO_W-1:0]        gpio_pullupb_o,
  output logic [gpio_pkg::GPIO_W-1:0]        gpio_pulldownb_o,
  output logic [gpio_pkg::IRQ_W-1:0]         irq_o
);
  import soc_map_pkg::*;
  import gpio_pkg::*;

  logic [7:0]        reg_off;
  logic [DATA_W-1:0] reg_wdata;
  logic [STRB_W-1:0] reg_we;
  logic [DATA_W-1:0] reg_rdata;
  logic [GPIO_W-1:0] gpio;
  logic [GPIO_W-1:0] gpio_oeb;
  logic [GPIO_W-1:0] gpio_pu;
  logic [GPIO_W-1:0] gpio_pd;
  pll_dest_e         pll_dest;
  trap_dest_e        trap_dest;
  irq_src_e          irq7_src;
  irq_src_e          irq8_src;

  mem_bus_fabric u_fabric (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_rdata_i (ram_rdata_i),
    .reg_off_o   (reg_off),
    .reg_wdata_o (reg_wdata),
    .reg_we_o    (reg_we),
    .reg_rdata_i (reg_rdata)
  );

  // pad outputs loop back for the GPIO_OUT read
  gpio_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_off_i   (reg_off),
    .reg_wdata_i (reg_wdata),
    .reg_we_i    (reg_we),
    .pin_out_i   (gpio_out_o),
    .gpio_in_i   (gpio_in_i),
    .reg_rdata_o (reg_rdata),
    .gpio_o      (gpio),
    .gpio_oeb_o  (gpio_oeb),
    .gpio_pu_o   (gpio_pu),
    .gpio_pd_o   (gpio_pd),
    .pll_dest_o  (pll_dest),
    .trap_dest_o (trap_dest),
    .irq7_src_o  (irq7_src),
    .irq8_src_o  (irq8_src)
  );

  gpio_pin_mux u_pins (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .trap_i           (trap_i),
    .gpio_in_i        (gpio_in_i),
    .irq_pin_i        (irq_pin_i),
    .irq_spi_i        (irq_spi_i),
    .gpio_i           (gpio),
    .gpio_oeb_i       (gpio_oeb),
    .gpio_pu_i        (gpio_pu),
    .gpio_pd_i        (gpio_pd),
    .pll_dest_i       (pll_dest),
    .trap_dest_i      (trap_dest),
    .irq7_src_i       (irq7_src),
    .irq8_src_i       (irq8_src),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_o            (irq_o)
  );

endmodule

`default_nettype wire

/* testbench/soc_periph_assert.sv */
// ============================
// Bus protocol checks for mem_bus_fabric.
// Assumes one outstanding request and a master that holds valid
// until it sees ready
// ============================
`timescale 1ns/100ps
`default_nettype none

module soc_periph_assert (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           mem_valid_i,
  input logic                           mem_ready_i,
  input logic [soc_map_pkg::STRB_W-1:0] ram_wstrb_i
);

  ready_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_i |=> !mem_ready_i)
    else $error("mem_ready_o stayed high for two cycles");

  // first cycle of a request must be answered on the next edge
  ready_one_cycle_late: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_valid_i && !mem_ready_i) |=> mem_ready_i)
    else $error("mem_ready_o did not follow mem_valid_i by one cycle");

  wstrb_first_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_wstrb_i != '0) |-> (mem_valid_i && !mem_ready_i))
    else $error("ram_wstrb_o active outside the first request cycle");

endmodule

`default_nettype wire

/* testbench/tb_soc_periph.sv */
// ============================
// Testbench for soc_periph_top. Run from the project root, it reads
// testbench/soc_periph_tests.txt; SRAM contents are random per seed
// ============================
`timescale 1ns/100ps
`default_nettype none

module tb_soc_periph;
  import soc_map_pkg::*;
  import gpio_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  mem_valid;
  logic [ADDR_W-1:0]     mem_addr;
  logic [DATA_W-1:0]     mem_wdata;
  logic [STRB_W-1:0]     mem_wstrb;
  logic                  mem_ready;
  logic [DATA_W-1:0]     mem_rdata;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic [DATA_W-1:0]     ram_wdata;
  logic [STRB_W-1:0]     ram_wstrb;
  logic [DATA_W-1:0]     ram_rdata;
  logic                  trap;
  logic [GPIO_W-1:0]     gpio_in;
  logic                  irq_pin;
  logic                  irq_spi;
  logic [GPIO_W-1:0]     gpio_out;
  logic [GPIO_W-1:0]     gpio_outenb;
  logic [GPIO_W-1:0]     gpio_pullupb;
  logic [GPIO_W-1:0]     gpio_pulldownb;
  logic [IRQ_W-1:0]      irq;

  logic [DATA_W-1:0]     ram_mem  [MEM_WORDS];
  logic [DATA_W-1:0]     ram_init [MEM_WORDS];
  int                    errors;

  // expected pull and routing register contents
  logic [GPIO_W-1:0]     pu_model;
  logic [GPIO_W-1:0]     pd_model;
  logic [1:0]            pll_model;
  logic [1:0]            trap_model;

  soc_periph_top uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .mem_valid_i      (mem_valid),
    .mem_addr_i       (mem_addr),
    .mem_wdata_i      (mem_wdata),
    .mem_wstrb_i      (mem_wstrb),
    .mem_ready_o      (mem_ready),
    .mem_rdata_o      (mem_rdata),
    .ram_addr_o       (ram_addr),
    .ram_wdata_o      (ram_wdata),
    .ram_wstrb_o      (ram_wstrb),
    .ram_rdata_i      (ram_rdata),
    .trap_i           (trap),
    .gpio_in_i        (gpio_in),
    .irq_pin_i        (irq_pin),
    .irq_spi_i        (irq_spi),
    .gpio_out_o       (gpio_out),
    .gpio_outenb_o    (gpio_outenb),
    .gpio_pullupb_o   (gpio_pullupb),
    .gpio_pulldownb_o (gpio_pulldownb),
    .irq_o            (irq)
  );

  bind mem_bus_fabric soc_periph_assert u_assert (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_ready_i (mem_ready_o),
    .ram_wstrb_i (ram_wstrb_o)
  );

  always #5 clk = ~clk;

  // synchronous SRAM returns read data one cycle after the address
  always @(posedge clk) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (ram_wstrb[b]) begin
        ram_mem[ram_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
      end
    end
    ram_rdata <= ram_mem[ram_addr];
  end

  function automatic logic [DATA_W-1:0] byte_mask(input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] m;
    m = '0;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) m[b*8 +: 8] = 8'hff;
    end
    return m;
  endfunction

  // routed pin groups have both pull bars high
  function automatic logic [GPIO_W-1:0] routed_pulls(input logic [1:0] pll_sel,
                                                     input logic [1:0] trap_sel);
    logic [GPIO_W-1:0] m;
    m = '0;
    if (pll_sel != PLL_NONE) m[10:8] = 3'b111;
    if (trap_sel != TRAP_NONE) m[13:11] = 3'b111;
    return m;
  endfunction

  task automatic track_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] m;
    logic [GPIO_W-1:0] keep;
    logic [GPIO_W-1:0] put;
    m    = byte_mask(strb);
    keep = ~m[GPIO_W-1:0];
    put  = wdata[GPIO_W-1:0] & m[GPIO_W-1:0];
    if (addr[ADDR_W-1:8] == MMIO_BASE_HI) begin
      case (addr[7:0])
        GPIO_PU:   pu_model = (pu_model & keep) | put;
        GPIO_PD:   pd_model = (pd_model & keep) | put;
        PLL_DEST:  if (strb[0]) pll_model = wdata[1:0];
        TRAP_DEST: if (strb[0]) trap_model = wdata[1:0];
        default:   ;
      endcase
    end
  endtask

  task automatic check_value(input logic [8*24-1:0] tname, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s expected 0x%08h actual 0x%08h", tname, expected, actual);
      errors++;
    end
  endtask

  // called just after a rising edge; leaves valid low from the next edge
  task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata,
                            output logic done);
    int cycles;
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= strb;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (mem_ready) begin
        done  = 1'b1;
        rdata = mem_rdata;
      end else begin
        cycles++;
      end
    end
    @(posedge clk);
    mem_valid <= 1'b0;
    mem_wstrb <= '0;
  endtask

  initial begin
    int               fd;
    int               fields;
    int               tests;
    int               passed;
    int               test_errs;
    logic [8*128-1:0] line_buf;
    logic [8*24-1:0]  tname;
    logic [7:0]       op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      strb_col;
    logic [31:0]      trap_col;
    logic [31:0]      gin_col;
    logic [31:0]      irq_col;
    logic [31:0]      exp_col;
    logic [31:0]      expected;
    logic [31:0]      actual;
    logic             got_ready;

    clk        = 1'b0;
    rst_n     <= 1'b0;
    mem_valid <= 1'b0;
    mem_addr  <= '0;
    mem_wdata <= '0;
    mem_wstrb <= '0;
    ram_rdata <= '0;
    trap      <= 1'b0;
    gpio_in   <= '0;
    irq_pin   <= 1'b0;
    irq_spi   <= 1'b0;
    errors     = 0;
    tests      = 0;
    passed     = 0;
    pu_model   = '0;
    pd_model   = '0;
    pll_model  = '0;
    trap_model = '0;

    void'($urandom(32'heb86));
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram_init[i] = $urandom();
      ram_mem[i] <= ram_init[i];
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("testbench/soc_periph_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/soc_periph_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        tname    = '0;
        if ($fgets(line_buf, fd) == 0) break;
        fields = $sscanf(line_buf, "%s %s %h %h %h %h %h %h %h", tname, op, addr, wdata,
                         strb_col, trap_col, gin_col, irq_col, exp_col);
        // comment and blank lines do not parse into all columns
        if (fields == 9) begin
          tests++;
          test_errs = errors;
          @(posedge clk);
          trap    <= trap_col[0];
          gpio_in <= gin_col[GPIO_W-1:0];
          irq_pin <= irq_col[0];
          irq_spi <= irq_col[1];
          case (op)
            "W", "R": begin
              if (op == "W") begin
                bus_access(addr, wdata, strb_col[STRB_W-1:0], actual, got_ready);
              end else begin
                bus_access(addr, wdata, '0, actual, got_ready);
              end
              if (!got_ready) begin
                $display("%0s stalled, no ready within %0d cycles", tname, TIMEOUT_CYCLES);
                errors++;
              end else if (op == "R") begin
                // unstrobed SRAM bytes come from the initial contents
                if (addr < RAM_LIMIT) begin
                  expected = (ram_init[addr[RAM_ADDR_W+1:2]] & ~byte_mask(strb_col[3:0]))
                           | (exp_col & byte_mask(strb_col[3:0]));
                end else begin
                  expected = exp_col;
                end
                check_value(tname, expected, actual);
              end else begin
                track_write(addr, wdata, strb_col[STRB_W-1:0]);
              end
            end
            "P": begin
              @(negedge clk);
              case (addr)
                0: check_value(tname, exp_col, {16'h0000, gpio_out});
                1: check_value(tname, exp_col, {16'h0000, gpio_outenb});
                2: check_value(tname, exp_col, irq);
                default: begin
                  $display("%0s uses an unknown pad selector %0d", tname, addr);
                  errors++;
                end
              endcase
              check_value(tname, {16'h0000, pu_model | routed_pulls(pll_model, trap_model)},
                          {16'h0000, gpio_pullupb});
              check_value(tname, {16'h0000, pd_model | routed_pulls(pll_model, trap_model)},
                          {16'h0000, gpio_pulldownb});
            end
            default: begin
              $display("%0s has an unknown operation", tname);
              errors++;
            end
          endcase
          if (errors == test_errs) begin
            passed++;
            $display("%0s: pass", tname);
          end else begin
            $display("%0s: fail", tname);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d passed, %0d errors", tests, passed, errors);
    if (errors == 0 && tests > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/soc_periph_tests.txt */
# columns: name op(W R P) addr wdata strb trap gpio_in irqs(bit0 pin, bit1 spi) expected
# R on SRAM takes strobed bytes from expected, rest from initial data; P addr 0 out 1 oeb 2 irq
rst_oeb      R 03000004 00000000 0 0 1234 0 0000ffff
rst_out      R 03000000 00000000 0 0 1234 0 00001234
ram_wr       W 00000100 deadbeef 5 0 1234 0 00000000
ram_rd       R 00000100 00000000 5 0 1234 0 deadbeef
ram_rd_init  R 00000204 00000000 0 0 1234 0 00000000
out_full     W 03000000 00003c5a 3 0 1234 0 00000000
out_hi       W 03000000 0000a5c3 2 0 1234 0 00000000
out_pads     P 00000000 00000000 0 0 1234 0 0000a55a
out_rd       R 03000000 00000000 0 0 1234 0 a55a1234
pu_wr        W 03000008 00001234 3 0 1234 0 00000000
pd_wr        W 0300000c 00008421 3 0 1234 0 00000000
pu_rd        R 03000008 00000000 0 0 1234 0 00001234
pd_rd        R 0300000c 00000000 0 0 1234 0 00008421
oeb_wr       W 03000004 0000f0f0 3 0 1234 0 00000000
trap_set     W 0300003c 00000002 1 1 1234 0 00000000
trap_out     P 00000000 00000000 0 1 1234 0 0000b55a
trap_oeb     P 00000001 00000000 0 1 1234 0 0000c0f0
trap_low     P 00000000 00000000 0 0 1234 0 0000a55a
trap_clr     W 0300003c 00000000 1 1 1234 0 00000000
trap_off     P 00000000 00000000 0 1 1234 0 0000a55a
trap_off_oeb P 00000001 00000000 0 1 1234 0 0000f0f0
irq8_set     W 03000044 00000002 1 0 0000 0 00000000
irq8_hi      P 00000002 00000000 0 0 0010 1 00000120
irq8_pins    P 00000002 00000000 0 0 0000 3 00000060
irq8_lo      P 00000002 00000000 0 0 ffef 0 00000000
unmapped     R 05000000 00000000 0 0 0000 0 00000000
above_ram    R 00020000 00000000 0 0 0000 0 00000000

/* flist.f */
hdl/soc_map_pkg.sv
hdl/gpio_pkg.sv
hdl/mem_bus_fabric.sv
hdl/gpio_regs.sv
hdl/gpio_pin_mux.sv
hdl/soc_periph_top.sv
testbench/soc_periph_assert.sv
testbench/tb_soc_periph.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
